//--- sim/turbo_dec_tb.sv
//////////////////////////////////////////////////////////////////////
// turbo decoder testbench that applies a table of encoded blocks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "turbo_settings.svh"

module turbo_dec_tb;

    localparam int NUM_ENTRIES  = 12;
    localparam int RESET_CYCLES = 10;
    localparam int ITER_CYCLES  = 32;
    localparam int ENTRY_CYCLES = `TURBO_BLK_LEN + `TURBO_MAX_ITER * ITER_CYCLES + 10;
    // the all-zero block runs after the table and counts as one more entry
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + (NUM_ENTRIES + 1) * ENTRY_CYCLES;
    localparam int ILV_ORDER [`TURBO_INFO_LEN] = '{0, 4, 2, 1, 3};

    logic                      clk_p_i;
    logic                      reset_n_i;
    logic                      in_valid_i;
    turbo_llr_pkg::ch_sample_t sys_i;
    turbo_llr_pkg::ch_sample_t par1_i;
    turbo_llr_pkg::ch_sample_t par2_i;
    logic                      in_ready_o;
    turbo_llr_pkg::info_bits_t dec_bits_o;
    logic                      done_o;

    turbo_llr_pkg::info_bits_t msg_tab [NUM_ENTRIES];
    logic                      corrupt_tab [NUM_ENTRIES];
    int                        cpos_tab [NUM_ENTRIES];
    logic                      gap_tab [NUM_ENTRIES];

    turbo_dec_top dut_i (
        .clk_p_i(clk_p_i), .reset_n_i(reset_n_i), .in_valid_i(in_valid_i),
        .sys_i(sys_i), .par1_i(par1_i), .par2_i(par2_i), .in_ready_o(in_ready_o),
        .dec_bits_o(dec_bits_o), .done_o(done_o)
    );

    initial begin
        clk_p_i = 1'b0;
        forever #10 clk_p_i = ~clk_p_i;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_bits(input string name, input turbo_llr_pkg::info_bits_t got,
                              input turbo_llr_pkg::info_bits_t exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // recursive code with feedback 1+D+D2 and parity 1+D2 over the state {s1, s2}
    task automatic rsc_encode(input turbo_llr_pkg::info_bits_t bits,
                              output logic [`TURBO_BLK_LEN-1:0] sys_bits,
                              output logic [`TURBO_BLK_LEN-1:0] par_bits);
        logic s1, s2, u, d;
        s1 = 1'b0;
        s2 = 1'b0;
        for (int k = 0; k < `TURBO_BLK_LEN; k++) begin
            // on the tail the input cancels the feedback so the encoder returns to 0
            u = (k < `TURBO_INFO_LEN) ? bits[k] : (s1 ^ s2);
            d = u ^ s1 ^ s2;
            sys_bits[k] = u;
            par_bits[k] = d ^ s2;
            s2 = s1;
            s1 = d;
        end
    endtask

    function automatic turbo_llr_pkg::ch_sample_t to_sample(input logic b);
        return b ? turbo_llr_pkg::ch_sample_t'(7) : turbo_llr_pkg::ch_sample_t'(-7);
    endfunction

    task automatic make_block(input turbo_llr_pkg::info_bits_t msg,
                              output turbo_llr_pkg::ch_block_t sys_blk,
                              output turbo_llr_pkg::ch_block_t par1_blk,
                              output turbo_llr_pkg::ch_block_t par2_blk);
        logic [`TURBO_BLK_LEN-1:0] sys_bits, par1_bits, ilv_sys_bits, par2_bits;
        turbo_llr_pkg::info_bits_t ilv_msg;
        for (int k = 0; k < `TURBO_INFO_LEN; k++) begin
            ilv_msg[k] = msg[ILV_ORDER[k]];
        end
        rsc_encode(msg, sys_bits, par1_bits);
        rsc_encode(ilv_msg, ilv_sys_bits, par2_bits);
        for (int k = 0; k < `TURBO_BLK_LEN; k++) begin
            sys_blk[k]  = to_sample(sys_bits[k]);
            par1_blk[k] = to_sample(par1_bits[k]);
            par2_blk[k] = to_sample(par2_bits[k]);
        end
    endtask

    // starts on a falling edge and returns on the falling edge after the last transfer
    task automatic send_block(input turbo_llr_pkg::ch_block_t sys_blk,
                              input turbo_llr_pkg::ch_block_t par1_blk,
                              input turbo_llr_pkg::ch_block_t par2_blk, input logic gap);
        for (int k = 0; k < `TURBO_BLK_LEN; k++) begin
            if (gap && k > 0) begin
                in_valid_i = 1'b0;
                sys_i      = turbo_llr_pkg::ch_sample_t'($urandom);
                @(negedge clk_p_i);
            end
            while (in_ready_o !== 1'b1) begin
                @(negedge clk_p_i);
            end
            in_valid_i = 1'b1;
            sys_i      = sys_blk[k];
            par1_i     = par1_blk[k];
            par2_i     = par2_blk[k];
            @(negedge clk_p_i);
        end
    endtask

    // junk samples are offered during the decode and must be refused
    task automatic wait_done(input turbo_llr_pkg::info_bits_t exp, output int cycles);
        cycles = 0;
        while (done_o !== 1'b1) begin
            check_flag("in_ready_o", in_ready_o, 1'b0);
            in_valid_i = 1'b1;
            sys_i      = turbo_llr_pkg::ch_sample_t'($urandom);
            par1_i     = turbo_llr_pkg::ch_sample_t'($urandom);
            par2_i     = turbo_llr_pkg::ch_sample_t'($urandom);
            @(negedge clk_p_i);
            cycles++;
        end
        in_valid_i = 1'b0;
        check_flag("in_ready_o", in_ready_o, 1'b0);
        check_bits("dec_bits_o", dec_bits_o, exp);
        @(negedge clk_p_i);
        check_flag("done_o", done_o, 1'b0);
        check_flag("in_ready_o", in_ready_o, 1'b1);
    endtask

    task automatic build_table();
        msg_tab = '{0: 5'b00000, 1: 5'b11111, 2: 5'b10110, 3: 5'b01001, default: '0};
        corrupt_tab = '{0: 1'b0, 1: 1'b0, 2: 1'b1, 3: 1'b1, default: 1'b0};
        cpos_tab = '{0: 0, 1: 0, 2: 2, 3: 4, default: 0};
        gap_tab = '{0: 1'b0, 1: 1'b1, 2: 1'b0, 3: 1'b1, default: 1'b0};
        for (int e = 4; e < NUM_ENTRIES; e++) begin
            msg_tab[e]     = turbo_llr_pkg::info_bits_t'($urandom);
            corrupt_tab[e] = (e % 3 == 0);
            cpos_tab[e]    = $urandom % `TURBO_INFO_LEN;
            gap_tab[e]     = e[0];
        end
    endtask

    initial begin
        int unsigned               seed_v;
        int unsigned               seed_ret;
        int                        cycles;
        turbo_llr_pkg::ch_block_t  sys_blk;
        turbo_llr_pkg::ch_block_t  par1_blk;
        turbo_llr_pkg::ch_block_t  par2_blk;
        seed_v     = 32'hc5a5f6d4;
        seed_ret   = $urandom(seed_v);
        reset_n_i  = 1'b0;
        in_valid_i = 1'b0;
        sys_i      = '0;
        par1_i     = '0;
        par2_i     = '0;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk_p_i);
        reset_n_i = 1'b1;
        @(negedge clk_p_i);
        check_flag("done_o", done_o, 1'b0);
        check_flag("in_ready_o", in_ready_o, 1'b1);

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            make_block(msg_tab[e], sys_blk, par1_blk, par2_blk);
            // a weak sample of the wrong sign on one systematic position
            if (corrupt_tab[e]) begin
                sys_blk[cpos_tab[e]] = msg_tab[e][cpos_tab[e]] ?
                    turbo_llr_pkg::ch_sample_t'(-1) : turbo_llr_pkg::ch_sample_t'(1);
            end
            send_block(sys_blk, par1_blk, par2_blk, gap_tab[e]);
            wait_done(msg_tab[e], cycles);
        end

        // every LLR is zero here, so both decoders return all ones and agree at once
        send_block('0, '0, '0, 1'b0);
        wait_done('1, cycles);
        if (cycles > ITER_CYCLES + 4) begin
            report_failure("all-zero block took more than one iteration");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_p_i);
        report_failure("watchdog expired before all blocks were decoded");
    end

endmodule

`default_nettype wire

//--- src/extrinsic_unit.sv
//////////////////////////////////////////////////////////////////////
// extrinsic unit: removes a-priori and channel terms from the APP
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "turbo_settings.svh"

module extrinsic_unit (
    input  wire turbo_llr_pkg::llr_block_t app_llr_i,
    input  wire turbo_llr_pkg::llr_block_t apriori_i,
    input  wire turbo_llr_pkg::ch_block_t  sys_i,
    output turbo_llr_pkg::llr_block_t      ext_llr_o,
    output turbo_llr_pkg::info_bits_t      hard_bits_o
);

    // tail positions carry no extrinsic value and stay at zero
    always_comb begin
        turbo_llr_pkg::llr_t diff;
        ext_llr_o = '0;
        for (int i = 0; i < `TURBO_INFO_LEN; i++) begin
            diff = turbo_llr_pkg::llr_sat_sub(app_llr_i[i], apriori_i[i]);
            ext_llr_o[i] = turbo_llr_pkg::llr_sat_sub(diff,
                turbo_llr_pkg::llr_t'(2 * $signed(sys_i[i])));
            // zero counts as a 1
            hard_bits_o[i] = ~app_llr_i[i][`TURBO_LLR_W-1];
        end
    end

endmodule

`default_nettype wire

//--- src/siso_maxlog.sv
//////////////////////////////////////////////////////////////////////
// max-log-MAP SISO engine over one terminated 4-state trellis
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "turbo_settings.svh"

module siso_maxlog (
    input  wire logic                      clk_p_i,
    input  wire logic                      reset_n_i,
    input  wire logic                      start_i,
    input  wire turbo_llr_pkg::ch_block_t  sys_i,
    input  wire turbo_llr_pkg::ch_block_t  par_i,
    input  wire turbo_llr_pkg::llr_block_t apriori_i,
    output logic                           finish_o,
    output turbo_llr_pkg::llr_block_t      app_llr_o
);

    localparam int NS = `TURBO_NUM_STATES;
    localparam logic [`TURBO_STEP_W-1:0] LAST_STEP = `TURBO_STEP_W'(`TURBO_BLK_LEN - 1);
    // stands in for the metric of a state that cannot be reached
    localparam turbo_llr_pkg::llr_t NEG_INF = {1'b1, {(`TURBO_LLR_W-1){1'b0}}};

    turbo_fsm_pkg::siso_phase_e phase_q;
    logic [`TURBO_STEP_W-1:0]   step_q;
    turbo_llr_pkg::llr_t        alpha_q [NS];
    turbo_llr_pkg::llr_t        beta_q [NS];
    turbo_llr_pkg::llr_t        alpha_mem [`TURBO_BLK_LEN][NS];
    turbo_llr_pkg::llr_t        alpha_d [NS];
    turbo_llr_pkg::llr_t        beta_d [NS];
    turbo_llr_pkg::llr_t        llr_d;

    // state is {s1, s2}; the feedback bit d = u ^ s1 ^ s2 and parity = d ^ s2
    always_comb begin
        turbo_llr_pkg::llr_t sys_term;
        turbo_llr_pkg::llr_t par_term;
        turbo_llr_pkg::llr_t gamma;
        turbo_llr_pkg::llr_t cand;
        turbo_llr_pkg::llr_t best0;
        turbo_llr_pkg::llr_t best1;
        turbo_llr_pkg::llr_t a_ref;
        turbo_llr_pkg::llr_t b_ref;
        logic [1:0]          st;
        logic [1:0]          ns;
        logic                d;
        sys_term = turbo_llr_pkg::llr_sat_add(apriori_i[step_q],
            turbo_llr_pkg::llr_t'(2 * $signed(sys_i[step_q])));
        par_term = turbo_llr_pkg::llr_t'(2 * $signed(par_i[step_q]));
        best0 = NEG_INF;
        best1 = NEG_INF;
        for (int s = 0; s < NS; s++) begin
            alpha_d[s] = NEG_INF;
            beta_d[s]  = NEG_INF;
        end
        for (int s = 0; s < NS; s++) begin
            for (int u = 0; u < 2; u++) begin
                st = 2'(s);
                d  = u[0] ^ st[1] ^ st[0];
                ns = {d, st[1]};
                // only the bits that are 1 contribute, which leaves the APP unchanged
                gamma = (u == 1) ? sys_term : '0;
                if (d ^ st[0]) begin
                    gamma = turbo_llr_pkg::llr_sat_add(gamma, par_term);
                end
                cand = turbo_llr_pkg::llr_sat_add(alpha_q[s], gamma);
                if (cand > alpha_d[ns]) begin
                    alpha_d[ns] = cand;
                end
                cand = turbo_llr_pkg::llr_sat_add(gamma, beta_q[ns]);
                if (cand > beta_d[s]) begin
                    beta_d[s] = cand;
                end
                cand = turbo_llr_pkg::llr_sat_add(alpha_mem[step_q][s], cand);
                if (u == 1 && cand > best1) begin
                    best1 = cand;
                end
                if (u == 0 && cand > best0) begin
                    best0 = cand;
                end
            end
        end
        // state 0 stays reachable in both directions, so it is the reference
        a_ref = alpha_d[0];
        b_ref = beta_d[0];
        for (int s = 0; s < NS; s++) begin
            alpha_d[s] = turbo_llr_pkg::llr_sat_sub(alpha_d[s], a_ref);
            beta_d[s]  = turbo_llr_pkg::llr_sat_sub(beta_d[s], b_ref);
        end
        llr_d = turbo_llr_pkg::llr_sat_sub(best1, best0);
    end

    always_ff @(posedge clk_p_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            phase_q  <= turbo_fsm_pkg::P_IDLE;
            step_q   <= '0;
            finish_o <= 1'b0;
        end else begin
            finish_o <= 1'b0;
            case (phase_q)
                turbo_fsm_pkg::P_IDLE: begin
                    if (start_i) begin
                        phase_q <= turbo_fsm_pkg::P_FWD;
                        step_q  <= '0;
                    end
                end
                turbo_fsm_pkg::P_FWD: begin
                    if (step_q == LAST_STEP) begin
                        phase_q <= turbo_fsm_pkg::P_BWD;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                turbo_fsm_pkg::P_BWD: begin
                    if (step_q == '0) begin
                        phase_q  <= turbo_fsm_pkg::P_IDLE;
                        finish_o <= 1'b1;
                    end else begin
                        step_q <= step_q - 1'b1;
                    end
                end
                default: phase_q <= turbo_fsm_pkg::P_IDLE;
            endcase
        end
    end

    // both recursions start from state 0, the encoder is terminated there
    always_ff @(posedge clk_p_i) begin
        if (phase_q == turbo_fsm_pkg::P_IDLE && start_i) begin
            for (int s = 0; s < NS; s++) begin
                alpha_q[s] <= (s == 0) ? '0 : NEG_INF;
            end
        end else if (phase_q == turbo_fsm_pkg::P_FWD) begin
            alpha_mem[step_q] <= alpha_q;
            alpha_q           <= alpha_d;
            if (step_q == LAST_STEP) begin
                for (int s = 0; s < NS; s++) begin
                    beta_q[s] <= (s == 0) ? '0 : NEG_INF;
                end
            end
        end else if (phase_q == turbo_fsm_pkg::P_BWD) begin
            beta_q            <= beta_d;
            app_llr_o[step_q] <= llr_d;
        end
    end

    start_when_idle_a : assert property (@(posedge clk_p_i) disable iff (!reset_n_i)
        start_i |-> phase_q == turbo_fsm_pkg::P_IDLE);

endmodule

`default_nettype wire

//--- src/turbo_ctrl.sv
//////////////////////////////////////////////////////////////////////
// turbo controller: runs the iterations, interleaves and stops early
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "turbo_settings.svh"

module turbo_ctrl (
    input  wire logic                      clk_p_i,
    input  wire logic                      reset_n_i,
    input  wire logic                      blk_loaded_i,
    input  wire turbo_llr_pkg::ch_block_t  sys_blk_i,
    input  wire turbo_llr_pkg::ch_block_t  par1_blk_i,
    input  wire turbo_llr_pkg::ch_block_t  par2_blk_i,
    input  wire logic                      siso_finish_i,
    input  wire turbo_llr_pkg::llr_block_t ext_llr_i,
    input  wire turbo_llr_pkg::info_bits_t hard_bits_i,
    output logic                           siso_start_o,
    output turbo_llr_pkg::ch_block_t       siso_sys_o,
    output turbo_llr_pkg::ch_block_t       siso_par_o,
    output turbo_llr_pkg::llr_block_t      siso_apriori_o,
    output logic                           blk_release_o,
    output turbo_llr_pkg::info_bits_t      dec_bits_o,
    output logic                           done_o
);

    // position k of decoder 2 reads information bit PERM[k]
    localparam int PERM [`TURBO_INFO_LEN] = '{0, 4, 2, 1, 3};

    turbo_fsm_pkg::dec_state_e  state_q;
    logic [`TURBO_ITER_W-1:0]   iter_q;
    turbo_llr_pkg::llr_block_t  ext1_q;
    turbo_llr_pkg::llr_block_t  ext2_q;
    turbo_llr_pkg::info_bits_t  hard1_q;
    turbo_llr_pkg::info_bits_t  hard2_nat;
    logic                       last_iter;

    // both extrinsic stores are in natural order, decoder 2 gets them interleaved
    always_comb begin
        siso_sys_o     = sys_blk_i;
        siso_par_o     = par1_blk_i;
        siso_apriori_o = ext2_q;
        hard2_nat      = '0;
        if (state_q == turbo_fsm_pkg::S_DEC2) begin
            siso_sys_o     = '0;
            siso_par_o     = par2_blk_i;
            siso_apriori_o = '0;
            for (int k = 0; k < `TURBO_INFO_LEN; k++) begin
                siso_sys_o[k]     = sys_blk_i[PERM[k]];
                siso_apriori_o[k] = ext1_q[PERM[k]];
            end
        end
        for (int k = 0; k < `TURBO_INFO_LEN; k++) begin
            hard2_nat[PERM[k]] = hard_bits_i[k];
        end
    end

    assign last_iter = (iter_q == `TURBO_ITER_W'(`TURBO_MAX_ITER - 1));

    always_ff @(posedge clk_p_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            state_q       <= turbo_fsm_pkg::S_READ;
            iter_q        <= '0;
            siso_start_o  <= 1'b0;
            blk_release_o <= 1'b0;
            done_o        <= 1'b0;
            dec_bits_o    <= '0;
            ext1_q        <= '0;
            ext2_q        <= '0;
            hard1_q       <= '0;
        end else begin
            siso_start_o  <= 1'b0;
            blk_release_o <= 1'b0;
            done_o        <= 1'b0;
            case (state_q)
                turbo_fsm_pkg::S_READ: begin
                    if (blk_loaded_i) begin
                        state_q      <= turbo_fsm_pkg::S_DEC1;
                        siso_start_o <= 1'b1;
                    end
                end
                turbo_fsm_pkg::S_DEC1: begin
                    if (siso_finish_i) begin
                        ext1_q       <= ext_llr_i;
                        hard1_q      <= hard_bits_i;
                        state_q      <= turbo_fsm_pkg::S_DEC2;
                        siso_start_o <= 1'b1;
                    end
                end
                turbo_fsm_pkg::S_DEC2: begin
                    if (siso_finish_i) begin
                        for (int k = 0; k < `TURBO_INFO_LEN; k++) begin
                            ext2_q[PERM[k]] <= ext_llr_i[k];
                        end
                        // agreeing decisions end the block early
                        if (hard2_nat == hard1_q || last_iter) begin
                            state_q       <= turbo_fsm_pkg::S_FINISH;
                            dec_bits_o    <= hard2_nat;
                            done_o        <= 1'b1;
                            blk_release_o <= 1'b1;
                        end else begin
                            iter_q       <= iter_q + 1'b1;
                            state_q      <= turbo_fsm_pkg::S_DEC1;
                            siso_start_o <= 1'b1;
                        end
                    end
                end
                default: begin
                    ext1_q  <= '0;
                    ext2_q  <= '0;
                    iter_q  <= '0;
                    state_q <= turbo_fsm_pkg::S_READ;
                end
            endcase
        end
    end

    done_single_cycle_a : assert property (@(posedge clk_p_i) disable iff (!reset_n_i)
        done_o |=> !done_o);

endmodule

`default_nettype wire

//--- src/turbo_dec_top.sv
//////////////////////////////////////////////////////////////////////
// turbo decoder top: buffer, controller, shared SISO and extrinsics
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module turbo_dec_top (
    input  wire logic                      clk_p_i,
    input  wire logic                      reset_n_i,
    input  wire logic                      in_valid_i,
    input  wire turbo_llr_pkg::ch_sample_t sys_i,
    input  wire turbo_llr_pkg::ch_sample_t par1_i,
    input  wire turbo_llr_pkg::ch_sample_t par2_i,
    output logic                           in_ready_o,
    output turbo_llr_pkg::info_bits_t      dec_bits_o,
    output logic                           done_o
);

    logic                      blk_loaded;
    logic                      blk_release;
    logic                      siso_start;
    logic                      siso_finish;
    turbo_llr_pkg::ch_block_t  sys_blk;
    turbo_llr_pkg::ch_block_t  par1_blk;
    turbo_llr_pkg::ch_block_t  par2_blk;
    turbo_llr_pkg::ch_block_t  siso_sys;
    turbo_llr_pkg::ch_block_t  siso_par;
    turbo_llr_pkg::llr_block_t siso_apriori;
    turbo_llr_pkg::llr_block_t app_llr;
    turbo_llr_pkg::llr_block_t ext_llr;
    turbo_llr_pkg::info_bits_t hard_bits;

    turbo_input_buffer buffer_i (
        .clk_p_i(clk_p_i), .reset_n_i(reset_n_i), .in_valid_i(in_valid_i),
        .sys_i(sys_i), .par1_i(par1_i), .par2_i(par2_i), .blk_release_i(blk_release),
        .in_ready_o(in_ready_o), .blk_loaded_o(blk_loaded),
        .sys_blk_o(sys_blk), .par1_blk_o(par1_blk), .par2_blk_o(par2_blk)
    );

    turbo_ctrl ctrl_i (
        .clk_p_i(clk_p_i), .reset_n_i(reset_n_i), .blk_loaded_i(blk_loaded),
        .sys_blk_i(sys_blk), .par1_blk_i(par1_blk), .par2_blk_i(par2_blk),
        .siso_finish_i(siso_finish), .ext_llr_i(ext_llr), .hard_bits_i(hard_bits),
        .siso_start_o(siso_start), .siso_sys_o(siso_sys), .siso_par_o(siso_par),
        .siso_apriori_o(siso_apriori), .blk_release_o(blk_release),
        .dec_bits_o(dec_bits_o), .done_o(done_o)
    );

    // one engine serves both constituent decoders in turn
    siso_maxlog siso_i (
        .clk_p_i(clk_p_i), .reset_n_i(reset_n_i), .start_i(siso_start),
        .sys_i(siso_sys), .par_i(siso_par), .apriori_i(siso_apriori),
        .finish_o(siso_finish), .app_llr_o(app_llr)
    );

    extrinsic_unit ext_i (
        .app_llr_i(app_llr), .apriori_i(siso_apriori), .sys_i(siso_sys),
        .ext_llr_o(ext_llr), .hard_bits_o(hard_bits)
    );

endmodule

`default_nettype wire

//--- src/turbo_fsm_pkg.sv
//////////////////////////////////////////////////////////////////////
// state encodings of the turbo controller and the SISO engine
//////////////////////////////////////////////////////////////////////
`default_nettype none

package turbo_fsm_pkg;

    typedef enum logic [1:0] {
        S_READ,
        S_DEC1,
        S_DEC2,
        S_FINISH
    } dec_state_e;

    typedef enum logic [1:0] {
        P_IDLE,
        P_FWD,
        P_BWD
    } siso_phase_e;

endpackage

`default_nettype wire

//--- src/turbo_input_buffer.sv
//////////////////////////////////////////////////////////////////////
// input buffer: gathers one block of channel triples under valid/ready
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "turbo_settings.svh"

module turbo_input_buffer (
    input  wire logic                     clk_p_i,
    input  wire logic                     reset_n_i,
    input  wire logic                     in_valid_i,
    input  wire turbo_llr_pkg::ch_sample_t sys_i,
    input  wire turbo_llr_pkg::ch_sample_t par1_i,
    input  wire turbo_llr_pkg::ch_sample_t par2_i,
    input  wire logic                     blk_release_i,
    output logic                          in_ready_o,
    output logic                          blk_loaded_o,
    output turbo_llr_pkg::ch_block_t      sys_blk_o,
    output turbo_llr_pkg::ch_block_t      par1_blk_o,
    output turbo_llr_pkg::ch_block_t      par2_blk_o
);

    localparam logic [`TURBO_STEP_W-1:0] LAST_STEP = `TURBO_STEP_W'(`TURBO_BLK_LEN - 1);

    logic [`TURBO_STEP_W-1:0] step_q;

    // ready stays low from the last sample until the decoder lets the block go
    always_ff @(posedge clk_p_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            step_q       <= '0;
            in_ready_o   <= 1'b1;
            blk_loaded_o <= 1'b0;
        end else begin
            blk_loaded_o <= 1'b0;
            if (in_valid_i && in_ready_o) begin
                if (step_q == LAST_STEP) begin
                    step_q       <= '0;
                    in_ready_o   <= 1'b0;
                    blk_loaded_o <= 1'b1;
                end else begin
                    step_q <= step_q + 1'b1;
                end
            end else if (blk_release_i) begin
                in_ready_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_p_i) begin
        if (in_valid_i && in_ready_o) begin
            sys_blk_o[step_q]  <= sys_i;
            par1_blk_o[step_q] <= par1_i;
            par2_blk_o[step_q] <= par2_i;
        end
    end

    loaded_not_ready_a : assert property (@(posedge clk_p_i) disable iff (!reset_n_i)
        blk_loaded_o |-> !in_ready_o);

endmodule

`default_nettype wire

//--- src/turbo_llr_pkg.sv
//////////////////////////////////////////////////////////////////////
// LLR and channel sample types with saturating arithmetic
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "turbo_settings.svh"

package turbo_llr_pkg;

    typedef logic signed [`TURBO_LLR_W-1:0] llr_t;
    typedef logic signed [`TURBO_CH_W-1:0]  ch_sample_t;
    typedef ch_sample_t [`TURBO_BLK_LEN-1:0] ch_block_t;
    typedef llr_t [`TURBO_BLK_LEN-1:0]       llr_block_t;
    typedef logic [`TURBO_INFO_LEN-1:0]      info_bits_t;

    // one guard bit catches the overflow, which then clamps to the rail
    function automatic llr_t llr_sat_add(input llr_t a, input llr_t b);
        logic signed [`TURBO_LLR_W:0] wide;
        wide = a + b;
        if (wide[`TURBO_LLR_W] != wide[`TURBO_LLR_W-1]) begin
            return wide[`TURBO_LLR_W] ? llr_t'({1'b1, {(`TURBO_LLR_W-1){1'b0}}})
                                      : llr_t'({1'b0, {(`TURBO_LLR_W-1){1'b1}}});
        end
        return llr_t'(wide[`TURBO_LLR_W-1:0]);
    endfunction

    function automatic llr_t llr_sat_sub(input llr_t a, input llr_t b);
        logic signed [`TURBO_LLR_W:0] wide;
        wide = a - b;
        if (wide[`TURBO_LLR_W] != wide[`TURBO_LLR_W-1]) begin
            return wide[`TURBO_LLR_W] ? llr_t'({1'b1, {(`TURBO_LLR_W-1){1'b0}}})
                                      : llr_t'({1'b0, {(`TURBO_LLR_W-1){1'b1}}});
        end
        return llr_t'(wide[`TURBO_LLR_W-1:0]);
    endfunction

endpackage

`default_nettype wire

//--- src/turbo_settings.svh
//////////////////////////////////////////////////////////////////////
// turbo decoder settings: widths, block lengths and iteration limits
//////////////////////////////////////////////////////////////////////
`ifndef TURBO_SETTINGS_SVH
`define TURBO_SETTINGS_SVH

// soft values and path metrics share one width
`define TURBO_LLR_W       13
`define TURBO_CH_W        4

`define TURBO_INFO_LEN    5
`define TURBO_TAIL_LEN    2
`define TURBO_BLK_LEN     (`TURBO_INFO_LEN + `TURBO_TAIL_LEN)
`define TURBO_NUM_STATES  4

`define TURBO_MAX_ITER    10
`define TURBO_ITER_W      4
`define TURBO_STEP_W      3

`endif

//--- turbo_dec.f
+incdir+src
src/turbo_llr_pkg.sv
src/turbo_fsm_pkg.sv
src/turbo_input_buffer.sv
src/siso_maxlog.sv
src/extrinsic_unit.sv
src/turbo_ctrl.sv
src/turbo_dec_top.sv
sim/turbo_dec_tb.sv
